//--- hw/bft_pkg.sv
package bft_pkg;

    // one packet word of the tree network.
    localparam int unsigned pkt_bits = 49;
    localparam int unsigned payload_bits = 32;

    // header field widths.
    localparam int unsigned leaf_bits = 5;
    localparam int unsigned port_bits = 4;
    localparam int unsigned addr_bits = 7;

    // field positions, valid flag on top.
    localparam int unsigned pkt_vld_bit = 48;
    localparam int unsigned leaf_lsb = 43;    // destination leaf.
    localparam int unsigned port_lsb = 39;    // destination port.
    localparam int unsigned addr_lsb = 32;    // address, stream number on the way out.

    // layout from the top down:
    //   [48]    valid
    //   [47:43] leaf
    //   [42:39] port
    //   [38:32] addr
    //   [31:0]  payload

endpackage

//--- hw/leaf_dest_table.sv
`timescale 1ns/1ps

module leaf_dest_table
    import bft_pkg::*;
(
    input  logic                           clk_400,
    input  logic                           rst_n,
    input  logic                           cfg_we,
    input  logic [addr_bits-1:0]           cfg_sel,
    input  logic [leaf_bits+port_bits-1:0] cfg_dest,
    output logic [2*leaf_bits-1:0]         dest_leaf,
    output logic [2*port_bits-1:0]         dest_port,
    output logic [1:0]                     dest_ok
);

    logic [1:0] hit;

    // entry i answers to select i+1, so streams are numbered 1 and 2.
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i] = cfg_we && (cfg_sel == addr_bits'(i + 1));
        end
    end

    always_ff @(posedge clk_400 or negedge rst_n) begin
        if (!rst_n) begin
            dest_ok <= '0;
        end else begin
            dest_ok <= dest_ok | hit;    // stays configured until reset.
        end
    end

    always_ff @(posedge clk_400) begin
        for (int i = 0; i < 2; i++) begin
            if (hit[i]) begin
                dest_leaf[i*leaf_bits +: leaf_bits] <= cfg_dest[port_bits +: leaf_bits];
                dest_port[i*port_bits +: port_bits] <= cfg_dest[port_bits-1:0];
            end
        end
    end

endmodule

//--- hw/leaf_i7o2.sv
`timescale 1ns/1ps

module leaf_i7o2
    import bft_pkg::*, leaf_pkg::*;
(
    input  logic                clk_400,
    input  logic                rst_n,
    input  logic [pkt_bits-1:0] din_leaf_bft2interface,
    output logic [pkt_bits-1:0] dout_leaf_interface2bft,
    input  logic                resend
);

    // router to kernel.
    logic [num_in_ports*payload_bits-1:0]  dout_leaf_interface2user;
    logic [num_in_ports-1:0]               vld_interface2user;
    logic [num_in_ports-1:0]               ack_user2interface;

    // kernel to packer.
    logic [num_out_ports*payload_bits-1:0] din_leaf_user2interface;
    logic [num_out_ports-1:0]              vld_user2interface;
    logic [num_out_ports-1:0]              ack_interface2user;

    // configuration path.
    logic                                  cfg_we;
    logic [addr_bits-1:0]                  cfg_sel;
    logic [leaf_bits+port_bits-1:0]        cfg_dest;
    logic [num_out_ports*leaf_bits-1:0]    dest_leaf;
    logic [num_out_ports*port_bits-1:0]    dest_port;
    logic [num_out_ports-1:0]              dest_ok;

    leaf_rx_router u_rx_router (
        .clk_400                  (clk_400),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .cfg_we                   (cfg_we),
        .cfg_sel                  (cfg_sel),
        .cfg_dest                 (cfg_dest)
    );

    leaf_dest_table u_dest_table (
        .clk_400   (clk_400),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_dest  (cfg_dest),
        .dest_leaf (dest_leaf),
        .dest_port (dest_port),
        .dest_ok   (dest_ok)
    );

    leaf_tx_packer u_tx_packer (
        .clk_400                 (clk_400),
        .rst_n                   (rst_n),
        .resend                  (resend),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .ack_interface2user      (ack_interface2user),
        .dest_leaf               (dest_leaf),
        .dest_port               (dest_port),
        .dest_ok                 (dest_ok),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    user_kernel u_user_kernel (
        .clk_400                  (clk_400),
        .rst_n                    (rst_n),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

//--- hw/leaf_pkg.sv
package leaf_pkg;

    // user side of the leaf.
    localparam int unsigned num_in_ports = 7;
    localparam int unsigned num_out_ports = 2;

    // port 0 carries configuration writes, 1 to 7 are user ports.
    localparam int unsigned cfg_port = 0;

    // kernel port roles.
    localparam int unsigned add_port_a = 1;
    localparam int unsigned add_port_b = 2;
    localparam int unsigned fwd_port_lo = 3;    // ports 3 and up are forwarded.

    // adder states.
    typedef enum logic {
        k_wait,    // waiting for both operands.
        k_hold     // sum waits for the packer.
    } kernel_state_e;

endpackage

//--- hw/leaf_rx_router.sv
`timescale 1ns/1ps

module leaf_rx_router
    import bft_pkg::*, leaf_pkg::*;
(
    input  logic                                   clk_400,
    input  logic                                   rst_n,
    input  logic [pkt_bits-1:0]                    din_leaf_bft2interface,
    output logic [num_in_ports*payload_bits-1:0]   dout_leaf_interface2user,
    output logic [num_in_ports-1:0]                vld_interface2user,
    input  logic [num_in_ports-1:0]                ack_user2interface,
    output logic                                   cfg_we,
    output logic [addr_bits-1:0]                   cfg_sel,
    output logic [leaf_bits+port_bits-1:0]         cfg_dest
);

    logic                    pkt_vld;
    logic [port_bits-1:0]    pkt_port;
    logic [num_in_ports-1:0] full;
    logic [num_in_ports-1:0] load;

    assign pkt_vld = din_leaf_bft2interface[pkt_vld_bit];
    assign pkt_port = din_leaf_bft2interface[port_lsb +: port_bits];

    // configuration writes go straight to the table.
    assign cfg_we = pkt_vld && (pkt_port == port_bits'(cfg_port));
    assign cfg_sel = din_leaf_bft2interface[addr_lsb +: addr_bits];
    assign cfg_dest = din_leaf_bft2interface[leaf_bits+port_bits-1:0];    // leaf then port.

    // slot i belongs to user port i+1.
    // a packet for a full slot is dropped.
    always_comb begin
        for (int i = 0; i < num_in_ports; i++) begin
            load[i] = pkt_vld && (pkt_port == port_bits'(i + 1)) && !full[i];
        end
    end

    always_ff @(posedge clk_400 or negedge rst_n) begin
        if (!rst_n) begin
            full <= '0;
        end else begin
            for (int i = 0; i < num_in_ports; i++) begin
                if (load[i]) begin
                    full[i] <= 1'b1;
                end else if (ack_user2interface[i]) begin
                    full[i] <= 1'b0;    // kernel took the word.
                end
            end
        end
    end

    always_ff @(posedge clk_400) begin
        for (int i = 0; i < num_in_ports; i++) begin
            if (load[i]) begin
                dout_leaf_interface2user[i*payload_bits +: payload_bits] <=
                    din_leaf_bft2interface[payload_bits-1:0];
            end
        end
    end

    assign vld_interface2user = full;

endmodule

//--- hw/leaf_tx_packer.sv
`timescale 1ns/1ps

module leaf_tx_packer
    import bft_pkg::*, leaf_pkg::*;
(
    input  logic                                    clk_400,
    input  logic                                    rst_n,
    input  logic                                    resend,
    input  logic [num_out_ports*payload_bits-1:0]   din_leaf_user2interface,
    input  logic [num_out_ports-1:0]                vld_user2interface,
    output logic [num_out_ports-1:0]                ack_interface2user,
    input  logic [num_out_ports*leaf_bits-1:0]      dest_leaf,
    input  logic [num_out_ports*port_bits-1:0]      dest_port,
    input  logic [num_out_ports-1:0]                dest_ok,
    output logic [pkt_bits-1:0]                     dout_leaf_interface2bft
);

    logic [num_out_ports-1:0] ready;
    logic                     any_ready;
    logic                     sel;           // stream index being granted.
    logic                     last_grant;
    logic [pkt_bits-1:0]      pkt_d;
    logic [pkt_bits-1:0]      pkt_q;

    assign ready = vld_user2interface & dest_ok & {num_out_ports{!resend}};
    assign any_ready = |ready;

    // round robin, the stream not served last wins a tie.
    always_comb begin
        if (&ready) begin
            sel = !last_grant;
        end else begin
            sel = ready[1];
        end
    end

    assign ack_interface2user = any_ready ? (num_out_ports'(1) << sel) : '0;

    always_comb begin
        pkt_d = '0;
        pkt_d[pkt_vld_bit] = 1'b1;
        pkt_d[leaf_lsb +: leaf_bits] = dest_leaf[sel*leaf_bits +: leaf_bits];
        pkt_d[port_lsb +: port_bits] = dest_port[sel*port_bits +: port_bits];
        pkt_d[addr_lsb +: addr_bits] = addr_bits'(sel) + addr_bits'(1);    // stream 1 or 2.
        pkt_d[payload_bits-1:0] = din_leaf_user2interface[sel*payload_bits +: payload_bits];
    end

    always_ff @(posedge clk_400 or negedge rst_n) begin
        if (!rst_n) begin
            last_grant <= 1'b0;
            pkt_q <= '0;
        end else begin
            pkt_q <= any_ready ? pkt_d : '0;    // one cycle per accepted word.
            if (any_ready) begin
                last_grant <= sel;
            end
        end
    end

    // the tree asks for silence while resend is up.
    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

endmodule

//--- hw/user_kernel.sv
`timescale 1ns/1ps

module user_kernel
    import bft_pkg::*, leaf_pkg::*;
(
    input  logic                                    clk_400,
    input  logic                                    rst_n,
    input  logic [num_in_ports*payload_bits-1:0]    dout_leaf_interface2user,
    input  logic [num_in_ports-1:0]                 vld_interface2user,
    output logic [num_in_ports-1:0]                 ack_user2interface,
    output logic [num_out_ports*payload_bits-1:0]   din_leaf_user2interface,
    output logic [num_out_ports-1:0]                vld_user2interface,
    input  logic [num_out_ports-1:0]                ack_interface2user
);

    kernel_state_e           state;
    logic                    add_take;
    logic [payload_bits-1:0] sum_q;
    logic                    fwd_full;
    logic                    fwd_room;
    logic [num_in_ports-1:0] fwd_ack;
    logic [payload_bits-1:0] fwd_word;
    logic [payload_bits-1:0] fwd_q;

    // adder takes both operands in one cycle.
    assign add_take = (state == k_wait) && vld_interface2user[add_port_a-1]
                      && vld_interface2user[add_port_b-1];

    always_ff @(posedge clk_400 or negedge rst_n) begin
        if (!rst_n) begin
            state <= k_wait;
        end else begin
            case (state)
                k_wait: if (add_take) state <= k_hold;
                k_hold: if (ack_interface2user[0]) state <= k_wait;
                default: state <= k_wait;
            endcase
        end
    end

    always_ff @(posedge clk_400) begin
        if (add_take) begin
            sum_q <= dout_leaf_interface2user[(add_port_a-1)*payload_bits +: payload_bits]
                     + dout_leaf_interface2user[(add_port_b-1)*payload_bits +: payload_bits];
        end
    end

    // forwarder, scanning down so the lowest valid port wins.
    assign fwd_room = !fwd_full || ack_interface2user[1];

    always_comb begin
        fwd_ack = '0;
        fwd_word = '0;
        for (int i = num_in_ports - 1; i >= int'(fwd_port_lo) - 1; i--) begin
            if (vld_interface2user[i]) begin
                fwd_ack = '0;
                fwd_ack[i] = fwd_room;
                fwd_word = dout_leaf_interface2user[i*payload_bits +: payload_bits];
            end
        end
    end

    always_ff @(posedge clk_400 or negedge rst_n) begin
        if (!rst_n) begin
            fwd_full <= 1'b0;
        end else if (|fwd_ack) begin
            fwd_full <= 1'b1;
        end else if (ack_interface2user[1]) begin
            fwd_full <= 1'b0;
        end
    end

    always_ff @(posedge clk_400) begin
        if (|fwd_ack) begin
            fwd_q <= fwd_word;
        end
    end

    always_comb begin
        ack_user2interface = fwd_ack;
        ack_user2interface[add_port_a-1] = add_take;
        ack_user2interface[add_port_b-1] = add_take;
    end

    assign din_leaf_user2interface = {fwd_q, sum_q};
    assign vld_user2interface = {fwd_full, state == k_hold};

endmodule

//--- leaf_i7o2.f
hw/bft_pkg.sv
hw/leaf_pkg.sv
hw/leaf_rx_router.sv
hw/leaf_dest_table.sv
hw/leaf_tx_packer.sv
hw/user_kernel.sv
hw/leaf_i7o2.sv
tb/leaf_i7o2_chk.sv
tb/tb_leaf_i7o2.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_leaf_i7o2 \
    -f leaf_i7o2.f -o sim_leaf_i7o2 \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/sim_leaf_i7o2 +verilator+error+limit+1000)"
echo "$sim_out"
echo "$sim_out" | grep -q "^Verification passed$" && exit 0 || exit 1

//--- tb/leaf_i7o2_chk.sv
`timescale 1ns/1ps

module leaf_i7o2_chk
    import bft_pkg::*, leaf_pkg::*;
(
    input logic                     clk_400,
    input logic                     rst_n,
    input logic                     resend,
    input logic [pkt_bits-1:0]      dout_leaf_interface2bft,
    input logic [num_out_ports-1:0] ack_interface2user
);

    int fail_cnt = 0;    // read by the testbench at the end.

    logic                              pkt_vld;
    logic [addr_bits+payload_bits-1:0] tag;    // stream number and payload.

    assign pkt_vld = dout_leaf_interface2bft[pkt_vld_bit];
    assign tag = dout_leaf_interface2bft[addr_lsb+addr_bits-1:0];

    // quiet in reset and one cycle beyond.
    a_reset_quiet: assert property (@(posedge clk_400)
        (!rst_n || $past(!rst_n)) |-> dout_leaf_interface2bft == '0)
    else begin
        $error("outbound packet during reset or in the first cycle after it");
        fail_cnt++;
    end

    a_resend_quiet: assert property (@(posedge clk_400) disable iff (!rst_n)
        $past(resend) |-> dout_leaf_interface2bft == '0)
    else begin
        $error("outbound packet in the cycle after resend was high");
        fail_cnt++;
    end

    // a repeated packet needs an accepted word behind each copy.
    a_no_stretch: assert property (@(posedge clk_400) disable iff (!rst_n)
        (pkt_vld && $past(pkt_vld) && tag == $past(tag))
        |-> ($past(|ack_interface2user) && $past(|ack_interface2user, 2)))
    else begin
        $error("outbound packet held for two cycles from one word");
        fail_cnt++;
    end

endmodule

bind leaf_i7o2 leaf_i7o2_chk u_chk (
    .clk_400                 (clk_400),
    .rst_n                   (rst_n),
    .resend                  (resend),
    .dout_leaf_interface2bft (dout_leaf_interface2bft),
    .ack_interface2user      (ack_interface2user)
);

//--- tb/tb_leaf_i7o2.sv
`timescale 1ns/1ps

module tb_leaf_i7o2
    import bft_pkg::*, leaf_pkg::*;
();

    localparam int max_cycles = 2000;    // the tests take about 200 cycles.

    logic                clk_400;
    logic                rst_n;
    logic                resend;
    logic [pkt_bits-1:0] din_leaf_bft2interface;
    logic [pkt_bits-1:0] dout_leaf_interface2bft;

    logic [pkt_bits-1:0] got_q[$];
    logic [31:0]         rng_state = 32'd69519;
    string               test_name;
    int                  cycles = 0;
    int                  tests = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  test_errors = 0;

    leaf_i7o2 u_dut (
        .clk_400                 (clk_400),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend)
    );

    initial begin
        clk_400 = 1'b0;
        forever #50 clk_400 = ~clk_400;
    end

    // collect every outbound packet, sampled mid cycle.
    always @(negedge clk_400) begin
        if (rst_n && dout_leaf_interface2bft[pkt_vld_bit]) begin
            got_q.push_back(dout_leaf_interface2bft);
        end
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk_400);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic logic [pkt_bits-1:0] make_pkt(input logic [leaf_bits-1:0] leaf,
                                                     input logic [port_bits-1:0] port,
                                                     input logic [addr_bits-1:0] addr,
                                                     input logic [payload_bits-1:0] word);
        return {1'b1, leaf, port, addr, word};
    endfunction

    task automatic send_pkt(input logic [pkt_bits-1:0] pkt);
        @(posedge clk_400);
        #1;
        din_leaf_bft2interface = pkt;
        @(posedge clk_400);
        #1;
        din_leaf_bft2interface = '0;
    endtask

    task automatic send_word(input logic [port_bits-1:0] port, input logic [31:0] word);
        send_pkt(make_pkt(5'd1, port, 7'd0, word));
    endtask

    task automatic set_dest(input logic [addr_bits-1:0] stream,
                            input logic [leaf_bits-1:0] leaf,
                            input logic [port_bits-1:0] port);
        send_pkt(make_pkt(5'd0, port_bits'(cfg_port), stream, {23'd0, leaf, port}));
    endtask

    task automatic set_resend(input logic value);
        @(posedge clk_400);
        #1;
        resend = value;
    endtask

    task automatic wait_pkts(input int n);
        while (got_q.size() < n) begin
            @(posedge clk_400);
        end
    endtask

    task automatic check_pkt(input logic [pkt_bits-1:0] exp);
        logic [pkt_bits-1:0] got;
        got = got_q.pop_front();
        checks++;
        assert (got === exp) else begin
            $display("** Error %s: expected %h, actual %h", test_name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_quiet();
        checks++;
        assert (got_q.size() == 0) else begin
            $display("** Error %s: expected 0 packets, actual %0d", test_name, got_q.size());
            errors++;
            test_errors++;
            got_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name, test_errors);
    endtask

    initial begin
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         c;
        logic [31:0]         fwd_words [5];
        logic [pkt_bits-1:0] p0;
        logic [pkt_bits-1:0] p1;
        logic [pkt_bits-1:0] e1;
        logic [pkt_bits-1:0] e2;
        int                  fails;

        rst_n = 1'b0;
        resend = 1'b0;
        din_leaf_bft2interface = '0;
        repeat (8) @(posedge clk_400);
        #1;
        rst_n = 1'b1;

        start_test("no_dest");
        a = lcg_next();
        b = lcg_next();
        send_word(4'd1, a);
        send_word(4'd2, b);
        repeat (10) @(posedge clk_400);
        check_quiet();
        set_dest(7'd1, 5'h0a, 4'h3);
        set_dest(7'd2, 5'h11, 4'h6);
        wait_pkts(1);
        check_pkt(make_pkt(5'h0a, 4'h3, 7'd1, a + b));
        end_test();

        start_test("sums");
        for (int i = 0; i < 10; i++) begin
            a = lcg_next();
            b = lcg_next();
            send_word(4'd1, a);
            send_word(4'd2, b);
            wait_pkts(1);
            check_pkt(make_pkt(5'h0a, 4'h3, 7'd1, a + b));
        end
        end_test();

        // stall the packer so ports 4 to 7 queue up behind port 3.
        start_test("fwd_order");
        for (int i = 0; i < 4; i++) begin
            fwd_words[i] = lcg_next();
        end
        fwd_words[4] = fwd_words[3];    // ports 6 and 7 carry the same word.
        set_resend(1'b1);
        send_word(4'd3, fwd_words[0]);
        for (int i = 4; i >= 1; i--) begin
            send_word(port_bits'(i + 3), fwd_words[i]);
        end
        repeat (2) @(posedge clk_400);
        set_resend(1'b0);
        wait_pkts(5);
        for (int i = 0; i < 5; i++) begin
            check_pkt(make_pkt(5'h11, 4'h6, 7'd2, fwd_words[i]));
        end
        end_test();

        start_test("resend");
        a = lcg_next();
        b = lcg_next();
        c = lcg_next();
        set_resend(1'b1);
        send_word(4'd1, a);
        send_word(4'd2, b);
        send_word(4'd3, c);
        repeat (13) @(posedge clk_400);
        check_quiet();
        set_resend(1'b0);
        wait_pkts(2);
        e1 = make_pkt(5'h0a, 4'h3, 7'd1, a + b);
        e2 = make_pkt(5'h11, 4'h6, 7'd2, c);
        p0 = got_q.pop_front();
        p1 = got_q.pop_front();
        checks++;
        assert ((p0 === e1 && p1 === e2) || (p0 === e2 && p1 === e1)) else begin
            $display("** Error %s: expected %h and %h in either order, actual %h and %h",
                     test_name, e1, e2, p0, p1);
            errors++;
            test_errors++;
        end
        end_test();

        start_test("reconfig");
        set_dest(7'd2, 5'h1e, 4'h2);
        c = lcg_next();
        send_word(4'd4, c);
        wait_pkts(1);
        check_pkt(make_pkt(5'h1e, 4'h2, 7'd2, c));
        send_pkt(make_pkt(5'd1, 4'd9, 7'd1, lcg_next()));    // no such port.
        repeat (10) @(posedge clk_400);
        check_quiet();
        end_test();

        fails = u_dut.u_chk.fail_cnt;
        $display("%0d tests, %0d checks, %0d check errors, %0d assertion failures",
                 tests, checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
